//--- Bender.yml
package:
  name: mem_system

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/mem_system_pkg.sv
      - common/cache_way_if.sv
      - common/mem_if.sv
      - cache/cache_way.sv
      - cache/cache_controller.sv
      - verilog/banked_memory.sv
      - verilog/mem_system.sv
  - target: test
    files:
      - tests/tb_clock.sv
      - tests/tb_mem_system.sv

//--- cache/cache_controller.sv
`include "mem_system_cfg.svh"

module cache_controller import mem_system_pkg::*; (
	input  logic      clk,
	input  logic      arst_n,
	input  addr_t     addr,
	input  data_t     data_in,
	input  logic      rd,
	input  logic      wr,
	output data_t     data_out,
	output logic      done,
	output logic      stall,
	output logic      cache_hit,
	output logic      err,
	cache_way_if.ctrl way0,
	cache_way_if.ctrl way1,
	mem_if.ctrl       mem
);

	ctrl_state_t state, state_nxt;

	addr_t    addr_q;
	data_t    data_q;
	logic     rd_q, wr_q;
	way_sel_t way_sel_q, way_sel_nxt;
	logic     victim_q, victim_nxt;

	logic     req;
	addr_t    cur_addr;
	data_t    cur_data;
	tag_t     cur_tag;
	index_t   cur_index;
	offset_t  cur_offset;

	tag_t     sel_tag;   // Tag of the chosen way
	data_t    sel_data;

	way_sel_t way_en;
	logic     way_comp, way_write, way_valid_in;
	offset_t  way_off;
	data_t    way_data;
	tag_t     mem_tag;
	offset_t  mem_off;

	assign req = rd | wr;

	// Live request in IDLE and captured request afterwards
	assign cur_addr   = (state == IDLE) ? addr : addr_q;
	assign cur_data   = (state == IDLE) ? data_in : data_q;
	assign cur_tag    = cur_addr[`ADDR_W-1 -: `TAG_W];
	assign cur_index  = cur_addr[`OFFSET_W +: `INDEX_W];
	assign cur_offset = cur_addr[`OFFSET_W-1:0];

	assign sel_tag  = way_sel_q[1] ? way1.tag_out : way0.tag_out;
	assign sel_data = way_sel_q[1] ? way1.data_rd : way0.data_rd;

	assign data_out = way1.hit ? way1.data_rd : way0.data_rd;

	always_comb begin
		state_nxt    = state;
		way_sel_nxt  = way_sel_q;
		victim_nxt   = victim_q;
		way_en       = 2'b00;
		way_comp     = 1'b0;
		way_write    = 1'b0;
		way_valid_in = 1'b0;
		way_off      = cur_offset;
		way_data     = cur_data;
		mem_tag      = cur_tag;
		mem_off      = '0;
		mem.wr       = 1'b0;
		mem.rd       = 1'b0;
		done         = 1'b0;
		stall        = 1'b1;
		cache_hit    = 1'b0;
		err          = 1'b0;

		case (state)
			IDLE: begin
				stall = 1'b0;
				if (req && cur_addr[0]) begin
					err = 1'b1;  // Misaligned request is dropped
				end else if (req) begin
					way_en    = 2'b11;
					way_comp  = 1'b1;
					way_write = wr;
					done      = way0.hit | way1.hit;
					cache_hit = done;
					stall     = ~done;
					if (!done)
						state_nxt = ENABLE;
				end
			end
			ENABLE: begin
				if (!way0.valid)
					way_sel_nxt = 2'b01;
				else if (!way1.valid)
					way_sel_nxt = 2'b10;
				else begin
					way_sel_nxt = victim_q ? 2'b10 : 2'b01;
					victim_nxt  = ~victim_q;  // Only on a real eviction
				end
				if (way_sel_nxt[1] ? (way1.valid & way1.dirty) : (way0.valid & way0.dirty))
					state_nxt = WB0;
				else
					state_nxt = REQ0;
			end
			WB0, WB1, WB2, WB3: begin
				way_en  = way_sel_q;
				way_off = {2'(state - WB0), 1'b0};  // Word k of the line
				mem_off = way_off;
				mem_tag = sel_tag;                  // Old line address
				mem.wr  = 1'b1;
				state_nxt = (state == WB3) ? REQ0 : ctrl_state_t'(state + 1'b1);
			end
			REQ0: begin
				mem.rd    = 1'b1;
				mem_off   = 3'b000;
				state_nxt = REQ1;
			end
			REQ1: begin
				mem.rd    = 1'b1;
				mem_off   = 3'b010;
				state_nxt = FILL0_REQ2;
			end
			FILL0_REQ2, FILL1_REQ3, FILL2, FILL3: begin
				way_en       = way_sel_q;
				way_write    = mem.data_valid;
				way_valid_in = 1'b1;
				way_data     = mem.data_rd;
				way_off      = {2'(state - FILL0_REQ2), 1'b0};
				if (state == FILL0_REQ2 || state == FILL1_REQ3) begin
					mem.rd  = 1'b1;
					mem_off = {2'(state - FILL0_REQ2 + 2'd2), 1'b0};
				end
				state_nxt = (state == FILL3) ? DONE : ctrl_state_t'(state + 1'b1);
			end
			DONE: begin
				way_en    = {2{rd_q | wr_q}};
				way_comp  = 1'b1;
				way_write = wr_q;
				done      = rd_q | wr_q;
				stall     = 1'b0;
				state_nxt = IDLE;
			end
			default: state_nxt = IDLE;
		endcase
	end

	// Both ways see the same access and the enables pick the active one
	assign way0.enable   = way_en[0];
	assign way1.enable   = way_en[1];
	assign way0.comp     = way_comp;
	assign way1.comp     = way_comp;
	assign way0.write    = way_write;
	assign way1.write    = way_write;
	assign way0.valid_in = way_valid_in;
	assign way1.valid_in = way_valid_in;
	assign way0.tag      = cur_tag;
	assign way1.tag      = cur_tag;
	assign way0.index    = cur_index;
	assign way1.index    = cur_index;
	assign way0.offset   = way_off;
	assign way1.offset   = way_off;
	assign way0.data_wr  = way_data;
	assign way1.data_wr  = way_data;

	assign mem.addr    = {mem_tag, cur_index, mem_off};
	assign mem.data_wr = sel_data;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state     <= IDLE;
			way_sel_q <= 2'b00;
			victim_q  <= 1'b0;
			rd_q      <= 1'b0;
			wr_q      <= 1'b0;
		end else begin
			state     <= state_nxt;
			way_sel_q <= way_sel_nxt;
			victim_q  <= victim_nxt;
			if (state == IDLE && req) begin
				rd_q <= rd;
				wr_q <= wr;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (state == IDLE && req) begin
			addr_q <= addr;
			data_q <= data_in;
		end
	end

endmodule

//--- cache/cache_way.sv
`include "mem_system_cfg.svh"

module cache_way import mem_system_pkg::*; (
	input logic      clk,
	input logic      arst_n,
	cache_way_if.way port
);

	tag_t  tag_mem  [`SETS];
	data_t data_mem [`SETS][`LINE_WORDS];
	logic [`SETS-1:0] valid_mem;
	logic [`SETS-1:0] dirty_mem;

	logic [$clog2(`LINE_WORDS)-1:0] word_sel;
	logic tag_match;
	logic wr_hit;   // Requester write in compare mode
	logic wr_fill;  // Direct write during refill

	// Byte offset to word within the line
	assign word_sel = port.offset[`OFFSET_W-1:1];

	assign tag_match = (tag_mem[port.index] == port.tag);

	// Reads are combinational from index and offset
	assign port.valid   = valid_mem[port.index];
	assign port.dirty   = dirty_mem[port.index];
	assign port.tag_out = tag_mem[port.index];
	assign port.data_rd = data_mem[port.index][word_sel];

	assign port.hit = port.enable & port.comp & port.valid & tag_match;

	assign wr_hit  = port.hit & port.write;
	assign wr_fill = port.enable & ~port.comp & port.write;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			valid_mem <= '0;
			dirty_mem <= '0;
		end else if (wr_hit) begin
			dirty_mem[port.index] <= 1'b1;
		end else if (wr_fill) begin
			valid_mem[port.index] <= port.valid_in;
			dirty_mem[port.index] <= 1'b0;  // Line now matches memory
		end
	end

	always_ff @(posedge clk) begin
		if (wr_hit || wr_fill)
			data_mem[port.index][word_sel] <= port.data_wr;
		if (wr_fill)
			tag_mem[port.index] <= port.tag;
	end

endmodule

//--- common/cache_way_if.sv
interface cache_way_if import mem_system_pkg::*; ();

	// Controller to way
	logic    enable;
	logic    comp;      // Compare mode
	logic    write;
	logic    valid_in;  // Valid bit stored on a fill
	tag_t    tag;
	index_t  index;
	offset_t offset;
	data_t   data_wr;

	// Way to controller
	logic    hit;
	logic    dirty;
	logic    valid;
	tag_t    tag_out;
	data_t   data_rd;

	modport ctrl (
		output enable, comp, write, valid_in, tag, index, offset, data_wr,
		input  hit, dirty, valid, tag_out, data_rd
	);

	modport way (
		input  enable, comp, write, valid_in, tag, index, offset, data_wr,
		output hit, dirty, valid, tag_out, data_rd
	);

endinterface

//--- common/mem_if.sv
interface mem_if import mem_system_pkg::*; ();

	addr_t addr;
	data_t data_wr;
	logic  wr;          // One-cycle strobe
	logic  rd;          // One-cycle strobe
	data_t data_rd;
	logic  data_valid;  // Read data of the strobe two cycles back

	modport ctrl (
		output addr, data_wr, wr, rd,
		input  data_rd, data_valid
	);

	modport mem (
		input  addr, data_wr, wr, rd,
		output data_rd, data_valid
	);

endinterface

//--- common/mem_system_cfg.svh
`ifndef MEM_SYSTEM_CFG_SVH
`define MEM_SYSTEM_CFG_SVH

// Address fields, byte addressed
`define ADDR_W      16
`define DATA_W      16
`define TAG_W       8   // Bits 15..8
`define INDEX_W     5   // Bits 7..3
`define OFFSET_W    3   // Bits 2..0

// Cache geometry, per way
`define SETS        32
`define LINE_WORDS  4

// Cycles from a read strobe to returned data
`define MEM_LATENCY 2

`endif

//--- common/mem_system_pkg.sv
`include "mem_system_cfg.svh"

package mem_system_pkg;

	typedef logic [`ADDR_W-1:0]   addr_t;   // Byte address
	typedef logic [`DATA_W-1:0]   data_t;   // One data word
	typedef logic [`TAG_W-1:0]    tag_t;
	typedef logic [`INDEX_W-1:0]  index_t;
	typedef logic [`OFFSET_W-1:0] offset_t;

	typedef logic [1:0] way_sel_t;  // One-hot, bit 0 is way 0

	// Miss handling sequence of the controller
	typedef enum logic [3:0] {
		IDLE,        // Hit path, request capture
		ENABLE,      // Pick a way
		WB0,         // Write back dirty line
		WB1,
		WB2,
		WB3,
		REQ0,        // First refill reads
		REQ1,
		FILL0_REQ2,  // Refill writes overlap the last reads
		FILL1_REQ3,
		FILL2,
		FILL3,
		DONE         // Replay the access in compare mode
	} ctrl_state_t;

endpackage

//--- files.f
+incdir+common
common/mem_system_pkg.sv
common/cache_way_if.sv
common/mem_if.sv
cache/cache_way.sv
cache/cache_controller.sv
verilog/banked_memory.sv
verilog/mem_system.sv
tests/tb_clock.sv
tests/tb_mem_system.sv

//--- tests/tb_clock.sv
module tb_clock (
	output logic clk,
	output logic arst_n
);
	timeunit 1ns;
	timeprecision 1ps;

	localparam int PERIOD_NS    = 8;
	localparam int RESET_CYCLES = 10;

	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2.0) clk = ~clk;
	end

	initial begin
		arst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;  // Release away from the active edge
	end

endmodule

//--- tests/tb_mem_system.sv
module tb_mem_system import mem_system_pkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLK_PERIOD        = 8;
	localparam int NUM_DIRECTED      = 13;  // Directed requests issued below
	localparam int NUM_RANDOM        = 300;
	localparam int NUM_REQUESTS      = NUM_DIRECTED + NUM_RANDOM;
	localparam int TIMEOUT_CYCLES    = NUM_REQUESTS * 14 + 20;
	localparam int CLEAN_MISS_CYCLES = 8;
	localparam int DIRTY_MISS_CYCLES = 12;

	typedef struct {
		logic  is_wr;
		data_t exp_data;
		logic  exp_hit;
		logic  exp_err;
		int    exp_cycles;   // Request cycle to done
		int    issue_cycle;
	} expect_t;

	logic  clk;
	logic  arst_n;
	addr_t addr;
	data_t data_in;
	logic  rd;
	logic  wr;
	data_t data_out;
	logic  done;
	logic  stall;
	logic  cache_hit;
	logic  err;

	int          errors     = 0;
	int          req_count  = 0;
	int          resp_count = 0;
	int          cycle      = 0;
	logic [15:0] lfsr       = 16'd16730;
	expect_t     exp_q [$];

	// Reference model of a flat word memory and the cache directory
	data_t ref_mem   [32768];
	tag_t  ref_tag   [2][32];
	logic  ref_valid [2][32];
	logic  ref_dirty [2][32];
	logic  ref_victim;

	tb_clock i_tb_clock (
		.clk    (clk),
		.arst_n (arst_n)
	);

	mem_system i_mem_system (
		.clk       (clk),
		.arst_n    (arst_n),
		.addr      (addr),
		.data_in   (data_in),
		.rd        (rd),
		.wr        (wr),
		.data_out  (data_out),
		.done      (done),
		.stall     (stall),
		.cache_hit (cache_hit),
		.err       (err)
	);

	always @(posedge clk)
		cycle <= cycle + 1;

	// Taps 16, 14, 13, 11
	function automatic logic next_lfsr_bit();
		logic fb;
		fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
		lfsr = {lfsr[14:0], fb};
		return fb;
	endfunction

	function automatic logic [15:0] random_bits(int n);
		logic [15:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
			v = {v[14:0], next_lfsr_bit()};
		return v;
	endfunction

	task automatic reset_model();
		foreach (ref_mem[i])
			ref_mem[i] = '0;
		for (int w = 0; w < 2; w++) begin
			for (int s = 0; s < 32; s++) begin
				ref_tag[w][s]   = '0;
				ref_valid[w][s] = 1'b0;
				ref_dirty[w][s] = 1'b0;
			end
		end
		ref_victim = 1'b0;
	endtask

	function automatic expect_t predict_access(addr_t a, data_t d, logic is_wr);
		expect_t e;
		tag_t    t;
		int      idx;
		int      way;
		e.is_wr       = is_wr;
		e.exp_data    = '0;
		e.exp_hit     = 1'b0;
		e.exp_err     = 1'b0;
		e.exp_cycles  = 0;
		e.issue_cycle = 0;
		if (a[0]) begin
			e.exp_err = 1'b1;  // Dropped request leaves the model untouched
			return e;
		end
		t   = a[15:8];
		idx = a[7:3];
		way = -1;
		for (int w = 0; w < 2; w++)
			if (ref_valid[w][idx] && ref_tag[w][idx] == t)
				way = w;
		if (way >= 0) begin
			e.exp_hit = 1'b1;
		end else begin
			if (!ref_valid[0][idx])
				way = 0;
			else if (!ref_valid[1][idx])
				way = 1;
			else begin
				way        = ref_victim;  // Toggle only on eviction of a valid line
				ref_victim = ~ref_victim;
			end
			e.exp_cycles = (ref_valid[way][idx] && ref_dirty[way][idx]) ?
				DIRTY_MISS_CYCLES : CLEAN_MISS_CYCLES;
			ref_tag[way][idx]   = t;
			ref_valid[way][idx] = 1'b1;
			ref_dirty[way][idx] = 1'b0;
		end
		if (is_wr) begin
			ref_dirty[way][idx] = 1'b1;
			ref_mem[a[15:1]]    = d;
		end
		e.exp_data = ref_mem[a[15:1]];
		return e;
	endfunction

	task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
		if (actual !== expected) begin
			errors++;
			$display("FAILED time %0t: %s expected 0x%0h actual 0x%0h",
				$time, name, expected, actual);
		end
	endtask

	task automatic issue_request(addr_t a, data_t d, logic is_wr);
		expect_t e;
		@(posedge clk);
		e             = predict_access(a, d, is_wr);
		e.issue_cycle = cycle + 1;  // Counter steps at this edge
		exp_q.push_back(e);
		req_count++;
		addr    <= a;
		data_in <= d;
		rd      <= ~is_wr;
		wr      <= is_wr;
		@(posedge clk);
		rd <= 1'b0;
		wr <= 1'b0;
		wait (resp_count == req_count);
	endtask

	// Combinational outputs are sampled mid-cycle
	always @(negedge clk) begin
		expect_t e;
		if (exp_q.size() > 0 && exp_q[0].issue_cycle == cycle)
			check_value("stall", !(exp_q[0].exp_hit || exp_q[0].exp_err), stall);
		if (done || err) begin
			if (exp_q.size() == 0) begin
				errors++;
				$display("Response at %0t with no request outstanding", $time);
			end else begin
				e = exp_q.pop_front();
				check_value("err", e.exp_err, err);
				check_value("done", !e.exp_err, done);
				if (!e.exp_err) begin
					check_value("cache_hit", e.exp_hit, cache_hit);
					check_value("latency", e.exp_cycles, cycle - e.issue_cycle);
					if (!e.is_wr)
						check_value("data_out", e.exp_data, data_out);
				end
				resp_count++;
			end
		end
	end

	initial begin
		addr_t a;
		data_t d;
		logic  is_wr;
		addr    = '0;
		data_in = '0;
		rd      = 1'b0;
		wr      = 1'b0;
		reset_model();
		wait (arst_n === 1'b1);
		@(negedge clk);
		check_value("done", 0, done);
		check_value("stall", 0, stall);
		check_value("cache_hit", 0, cache_hit);
		check_value("err", 0, err);

		issue_request(16'h0104, 16'h0000, 1'b0);  // Cold read is a clean miss
		issue_request(16'h0208, 16'ha5c3, 1'b1);  // Write miss
		issue_request(16'h0208, 16'h0000, 1'b0);  // Then a hit
		// Three tags on index 2 force dirty evictions
		issue_request(16'h0310, 16'h1111, 1'b1);
		issue_request(16'h0410, 16'h2222, 1'b1);
		issue_request(16'h0514, 16'h3333, 1'b1);
		issue_request(16'h0310, 16'h0000, 1'b0);
		issue_request(16'h0514, 16'h0000, 1'b0);
		issue_request(16'h0410, 16'h0000, 1'b0);
		issue_request(16'h0310, 16'h0000, 1'b0);
		// Misaligned requests leave everything alone
		issue_request(16'h0311, 16'hdead, 1'b1);
		issue_request(16'h0209, 16'h0000, 1'b0);
		issue_request(16'h0310, 16'h0000, 1'b0);

		for (int i = 0; i < NUM_RANDOM; i++) begin
			a       = '0;
			a[15:8] = 8'h30 + 8'(random_bits(2));  // Few tags and indices
			a[4:3]  = 2'(random_bits(2));
			a[2:1]  = 2'(random_bits(2));
			a[0]    = (random_bits(4) == 16'd0);
			is_wr   = 1'(random_bits(1));
			d       = random_bits(16);
			issue_request(a, d, is_wr);
		end

		repeat (4) @(posedge clk);
		$display("%0d requests, %0d responses, %0d errors", req_count, resp_count, errors);
		if (errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

	initial begin
		#(TIMEOUT_CYCLES * CLK_PERIOD);
		$display("Timeout after %0d cycles, the DUT stopped responding (%0d errors so far)",
			TIMEOUT_CYCLES, errors);
		$display("TEST FAILED");
		$finish;
	end

endmodule

//--- verilog/banked_memory.sv
`include "mem_system_cfg.svh"

module banked_memory import mem_system_pkg::*; (
	input logic clk,
	input logic arst_n,
	mem_if.mem  port
);

	localparam int WORD_IDX_W = `ADDR_W - `OFFSET_W;
	localparam int BANK_DEPTH = 2 ** WORD_IDX_W;

	data_t bank_mem [`LINE_WORDS][BANK_DEPTH];

	logic [1:0]            bank_sel;
	logic [WORD_IDX_W-1:0] word_idx;
	logic [1:0]            bank_q;    // First read stage
	logic [WORD_IDX_W-1:0] word_q;
	data_t                 data_q;    // Second read stage
	logic [`MEM_LATENCY-1:0] rd_pipe;

	// Consecutive words of a line sit in different banks
	assign bank_sel = port.addr[2:1];
	assign word_idx = port.addr[`ADDR_W-1:`OFFSET_W];

	// Simulation contents start cleared
	initial begin
		for (int b = 0; b < `LINE_WORDS; b++) begin
			for (int w = 0; w < BANK_DEPTH; w++) begin
				bank_mem[b][w] = '0;
			end
		end
	end

	always @(posedge clk) begin
		if (port.wr)
			bank_mem[bank_sel][word_idx] <= port.data_wr;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			rd_pipe <= '0;
		else
			rd_pipe <= {rd_pipe[`MEM_LATENCY-2:0], port.rd};
	end

	always_ff @(posedge clk) begin
		if (port.rd) begin
			bank_q <= bank_sel;
			word_q <= word_idx;
		end
		if (rd_pipe[0])
			data_q <= bank_mem[bank_q][word_q];
	end

	assign port.data_rd    = data_q;
	assign port.data_valid = rd_pipe[`MEM_LATENCY-1];

endmodule

//--- verilog/mem_system.sv
module mem_system import mem_system_pkg::*; (
	input  logic  clk,
	input  logic  arst_n,
	input  addr_t addr,
	input  data_t data_in,
	input  logic  rd,
	input  logic  wr,
	output data_t data_out,
	output logic  done,
	output logic  stall,
	output logic  cache_hit,
	output logic  err
);

	cache_way_if way0_if ();
	cache_way_if way1_if ();
	mem_if       mem_bus ();

	cache_controller i_cache_controller (
		.clk       (clk),
		.arst_n    (arst_n),
		.addr      (addr),
		.data_in   (data_in),
		.rd        (rd),
		.wr        (wr),
		.data_out  (data_out),
		.done      (done),
		.stall     (stall),
		.cache_hit (cache_hit),
		.err       (err),
		.way0      (way0_if.ctrl),
		.way1      (way1_if.ctrl),
		.mem       (mem_bus.ctrl)
	);

	cache_way i_cache_way0 (
		.clk    (clk),
		.arst_n (arst_n),
		.port   (way0_if.way)
	);

	cache_way i_cache_way1 (
		.clk    (clk),
		.arst_n (arst_n),
		.port   (way1_if.way)
	);

	banked_memory i_banked_memory (
		.clk    (clk),
		.arst_n (arst_n),
		.port   (mem_bus.mem)
	);

endmodule
